// ==== build.f ====
+incdir+hw
hw/link_clk_pkg.sv
hw/clock_input_sync.sv
hw/heartbeat_gen.sv
hw/reset_sequencer.sv
hw/pll_lock_model.sv
hw/link_clocks_top.sv
dv/link_clocks_assertions.sv
dv/link_clocks_tb.sv

// ==== dv/link_clocks_assertions.sv ====
//##########################################################
// reset sequencer checks: reset ordering, tick stepping,
// no PLL reset while the link runs
//##########################################################
`timescale 1ns/100ps

module link_clocks_assertions
   import link_clk_pkg::*;
(
   input logic       sys_clk,
   input logic       reset_in,
   input logic       tick,      // heartbeat step
   input seq_state_t state,     // sequencer state register
   input seq_ctrl_t  ctrl       // registered reset outputs
);

   //##########################################################
   // reset ordering
   //##########################################################

   // link logic only runs with the chip out of reset
   link_after_chip: assert property (@(posedge sys_clk) disable iff (reset_in)
      !ctrl.link_reset |-> ctrl.chip_reset_n)
   else
      $error("link_reset released while chip_reset_n still low");

   //##########################################################
   // stepping and active state
   //##########################################################

   // no tick, no way out of RESET_ALL
   reset_all_on_tick: assert property (@(posedge sys_clk) disable iff (reset_in)
      (state == RESET_ALL && !tick) |=> (state == RESET_ALL))
   else
      $error("sequencer left RESET_ALL without a heartbeat tick");

   // plls must be running once the link is up
   active_no_pll_reset: assert property (@(posedge sys_clk) disable iff (reset_in)
      (state == ACTIVE) |-> !ctrl.pll_reset)
   else
      $error("pll_reset high in ACTIVE");

endmodule

// ==== dv/link_clocks_tb.sv ====
//##########################################################
// link clock block testbench covering reset values, power-up
// order, lock delays, strobes, disable and restart
//##########################################################
`timescale 1ns/100ps
`include "link_clk_consts.svh"

module link_clocks_tb
   import link_clk_pkg::*;
();

   localparam int HB_PERIOD = 1 << `LINK_HB_WIDTH;       // cycles per heartbeat tick
   localparam int CORE_LOCK = `LINK_CORE_LOCK_CYCLES;
   localparam int RX_LOCK   = `LINK_RX_LOCK_CYCLES;
   localparam int SYNC      = `LINK_SYNC_STAGES;
   // two lock waits, remaining heartbeat steps, some margin
   localparam int POWERUP_BOUND = 2 * (CORE_LOCK + SYNC + HB_PERIOD) + 4 * HB_PERIOD + 32;

   logic         sys_clk;
   logic         reset_in;
   logic         link_en;
   seq_ctrl_t    ctrl;
   lock_status_t lock;
   logic         tx_div_en;
   logic         rx_div_en;
   int           mismatches;
   int           timeouts;

   link_clocks_top UUT
   (
      .sys_clk   (sys_clk),
      .reset_in  (reset_in),
      .link_en   (link_en),
      .ctrl      (ctrl),
      .lock      (lock),
      .tx_div_en (tx_div_en),
      .rx_div_en (rx_div_en)
   );

   bind reset_sequencer link_clocks_assertions u_assert
   (
      .sys_clk  (sys_clk),
      .reset_in (reset_in),
      .tick     (tick),
      .state    (state),
      .ctrl     (ctrl)
   );

   initial
   begin
      sys_clk = 1'b0;
      forever #4 sys_clk = ~sys_clk;   // 8 ns period
   end

   //##########################################################
   // checks
   //##########################################################

   task automatic check_bit(input string test, input string what, input logic expected,
                            input logic actual);
      assert (expected === actual)
      else
      begin
         mismatches++;
         $display("MISMATCH %s: %s expected %b actual %b", test, what, expected, actual);
      end
   endtask

   task automatic check_count(input string test, input string what, input int expected,
                              input int actual);
      assert (expected == actual)
      else
      begin
         mismatches++;
         $display("MISMATCH %s: %s expected %0d actual %0d", test, what, expected, actual);
      end
   endtask

   task automatic check_ctrl(input string test, input seq_ctrl_t expected,
                             input seq_ctrl_t actual);
      assert (expected === actual)
      else
      begin
         mismatches++;
         $display("MISMATCH %s: ctrl expected %b actual %b", test, expected, actual);
      end
   endtask

   task automatic check_done(input string test, input string what, input logic done);
      assert (done)
      else
      begin
         timeouts++;
         $display("TIMEOUT %s: %s did not happen within the wait limit", test, what);
      end
   endtask

   // pll held, chip held, link held, no lock, no strobes
   task automatic check_all_reset(input string test);
      check_bit(test, "pll_reset", 1'b1, ctrl.pll_reset);
      check_bit(test, "chip_reset_n", 1'b0, ctrl.chip_reset_n);
      check_bit(test, "link_reset", 1'b1, ctrl.link_reset);
      check_bit(test, "core_locked", 1'b0, lock.core_locked);
      check_bit(test, "rx_locked", 1'b0, lock.rx_locked);
      check_bit(test, "tx_div_en", 1'b0, tx_div_en);
      check_bit(test, "rx_div_en", 1'b0, rx_div_en);
   endtask

   // ctrl after each power-up step as {pll_reset, chip_reset_n, link_reset}
   function automatic seq_ctrl_t ctrl_for_step(input int step);
      seq_ctrl_t c;
      case (step)
         0:       c = '{pll_reset: 1'b0, chip_reset_n: 1'b0, link_reset: 1'b1};  // plls start
         1:       c = '{pll_reset: 1'b1, chip_reset_n: 1'b0, link_reset: 1'b1};  // quiet window
         2:       c = '{pll_reset: 1'b1, chip_reset_n: 1'b1, link_reset: 1'b1};  // chip out
         3:       c = '{pll_reset: 1'b0, chip_reset_n: 1'b1, link_reset: 1'b1};  // relock
         4:       c = '{pll_reset: 1'b0, chip_reset_n: 1'b1, link_reset: 1'b0};  // link up
         default: c = '{pll_reset: 1'b1, chip_reset_n: 1'b0, link_reset: 1'b1};
      endcase
      return c;
   endfunction

   //##########################################################
   // tests
   //##########################################################

   task automatic apply_reset();
      int i;
      reset_in = 1'b1;
      link_en  = 1'b0;
      for (i = 0; i < 5; i++)
         @(negedge sys_clk);
      reset_in = 1'b0;
   endtask

   // everything stays held with link_en low
   task automatic test_reset_values(input string test);
      int i;
      link_en = 1'b0;
      for (i = 0; i < 4 * HB_PERIOD; i++)
      begin
         @(negedge sys_clk);
         check_all_reset(test);
      end
   endtask

   // ordered reset edges and lock delays up to the link_reset fall
   task automatic run_power_up(input string test);
      int           step;
      int           t;
      int           t_fall;      // last pll_reset fall
      int           t_rise;      // last pll_reset rise
      int           n_core_up;
      int           n_rx_up;
      int           n_core_down;
      int           n_rx_down;
      seq_ctrl_t    prev;
      lock_status_t prev_lock;
      step        = 0;
      t_fall      = 0;
      t_rise      = 0;
      n_core_up   = 0;
      n_rx_up     = 0;
      n_core_down = 0;
      n_rx_down   = 0;
      prev        = ctrl;
      prev_lock   = lock;
      link_en     = 1'b1;
      for (t = 1; t <= POWERUP_BOUND && step < 5; t++)
      begin
         @(negedge sys_clk);
         if (ctrl != prev)
         begin
            check_ctrl(test, ctrl_for_step(step), ctrl);
            step++;
         end
         if (prev.pll_reset && !ctrl.pll_reset)
            t_fall = t;
         if (!prev.pll_reset && ctrl.pll_reset)
            t_rise = t;
         if (!prev_lock.core_locked && lock.core_locked)
         begin
            check_count(test, "core lock delay", CORE_LOCK, t - t_fall);
            n_core_up++;
         end
         if (!prev_lock.rx_locked && lock.rx_locked)
         begin
            check_count(test, "rx lock delay", RX_LOCK, t - t_fall);
            n_rx_up++;
         end
         if (prev_lock.core_locked && !lock.core_locked)
         begin
            check_count(test, "core lock drop delay", 1, t - t_rise);
            n_core_down++;
         end
         if (prev_lock.rx_locked && !lock.rx_locked)
         begin
            check_count(test, "rx lock drop delay", 1, t - t_rise);
            n_rx_down++;
         end
         if (ctrl.pll_reset)
         begin
            check_bit(test, "tx_div_en under pll_reset", 1'b0, tx_div_en);
            check_bit(test, "rx_div_en under pll_reset", 1'b0, rx_div_en);
         end
         prev      = ctrl;
         prev_lock = lock;
      end
      check_done(test, "link_reset release", step == 5);
      check_bit(test, "core_locked at end", 1'b1, lock.core_locked);
      // lock in both pll start phases, one drop at the quiet window
      check_count(test, "core lock rises", 2, n_core_up);
      check_count(test, "rx lock rises", 2, n_rx_up);
      check_count(test, "core lock drops", 1, n_core_down);
      check_count(test, "rx lock drops", 1, n_rx_down);
   endtask

   // strobe period while ACTIVE
   task automatic test_strobe_spacing(input string test);
      int t;
      int last_tx;
      int last_rx;
      int n_tx;
      int n_rx;
      last_tx = -1;
      last_rx = -1;
      n_tx    = 0;
      n_rx    = 0;
      for (t = 0; t < 16 * `LINK_TX_DIV + 16 * `LINK_RX_DIV; t++)
      begin
         @(negedge sys_clk);
         check_bit(test, "pll_reset in ACTIVE", 1'b0, ctrl.pll_reset);
         if (tx_div_en)
         begin
            if (last_tx >= 0)
               check_count(test, "tx strobe spacing", `LINK_TX_DIV, t - last_tx);
            last_tx = t;
            n_tx++;
         end
         if (rx_div_en)
         begin
            if (last_rx >= 0)
               check_count(test, "rx strobe spacing", `LINK_RX_DIV, t - last_rx);
            last_rx = t;
            n_rx++;
         end
      end
      check_done(test, "tx strobes", n_tx >= 4);
      check_done(test, "rx strobes", n_rx >= 4);
   endtask

   // link_en dropped after random hold times anywhere in the sequence
   task automatic test_disable_restart(input string test);
      int round;
      int hold;
      int i;
      for (round = 0; round < 6; round++)
      begin
         hold    = $urandom_range(POWERUP_BOUND, 1);
         link_en = 1'b1;
         for (i = 0; i < hold; i++)
            @(negedge sys_clk);
         link_en = 1'b0;
         for (i = 0; i < 4; i++)    // sync, state, lock drop
            @(negedge sys_clk);
         check_all_reset(test);
      end
      run_power_up(test);           // full order again after restart
   endtask

   //##########################################################
   // main sequence
   //##########################################################

   initial
   begin
      void'($urandom(96035));
      mismatches = 0;
      timeouts   = 0;
      reset_in   = 1'b1;
      link_en    = 1'b0;
      apply_reset();
      test_reset_values("reset_values");
      run_power_up("power_up_order");
      test_strobe_spacing("strobe_spacing");
      test_disable_restart("disable_restart");
      test_strobe_spacing("strobe_after_restart");
      $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== hw/clock_input_sync.sv ====
//##########################################################
// input synchronizers: link enable pin and PLL lock flags
//##########################################################
`timescale 1ns/100ps
`include "link_clk_consts.svh"

module clock_input_sync
   import link_clk_pkg::*;
(
   input  logic         sys_clk,
   input  logic         reset_in,
   input  logic         link_en,       // async pin or register
   input  lock_status_t lock,          // raw pll lock flags
   output logic         link_en_sync,
   output lock_status_t lock_sync
);

   localparam int STAGES = `LINK_SYNC_STAGES;

   //##########################################################
   // flop chains, oldest sample at the top index
   //##########################################################

   logic         [STAGES-1:0] en_q;    // enable chain
   lock_status_t [STAGES-1:0] lock_q;  // one chain per lock flag, side by side

   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         // disabled and unlocked, no stale lock seen after reset
         en_q   <= '0;
         lock_q <= '0;
      end
      else
      begin
         en_q   <= {en_q[STAGES-2:0], link_en};   // shift in new sample
         lock_q <= {lock_q[STAGES-2:0], lock};
      end
   end

   // last stage drives the sequencer, STAGES cycles behind the pin
   assign link_en_sync = en_q[STAGES-1];
   assign lock_sync    = lock_q[STAGES-1];

endmodule

// ==== hw/heartbeat_gen.sv ====
//##########################################################
// heartbeat: free-running counter, one-cycle tick per wrap
//##########################################################
`timescale 1ns/100ps

module heartbeat_gen
#(
   parameter int WIDTH = 4            // tick every 2**WIDTH cycles
)
(
   input  logic sys_clk,
   input  logic reset_in,
   output logic tick                  // one cycle high per period
);

   logic [WIDTH-1:0] count;

   // wrapping counter, registered zero detect
   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         count <= '0;
         tick  <= 1'b0;
      end
      else
      begin
         count <= count + 1'b1;      // wraps on its own
         tick  <= (count == '0);     // high once per wrap
      end
   end

endmodule

// ==== hw/link_clk_consts.svh ====
//##########################################################
// link clock block constants: heartbeat, PLL lock model
// delays, strobe divide ratios and synchronizer depth
//##########################################################
`ifndef LINK_CLK_CONSTS_SVH
`define LINK_CLK_CONSTS_SVH

//##########################################################
// sequencer timing base
//##########################################################

// heartbeat counter width, one tick per 2**width cycles
`define LINK_HB_WIDTH          4

//##########################################################
// PLL stand-in
//##########################################################

`define LINK_CORE_LOCK_CYCLES  40   // core/tx pll, cycles from reset release to lock
`define LINK_RX_LOCK_CYCLES    24   // rx pll lock delay

// clock-enable strobes in place of the divided clocks
`define LINK_TX_DIV            4    // tx parallel clock ratio
`define LINK_RX_DIV            4    // rx parallel clock ratio

//##########################################################
// input conditioning
//##########################################################

// flops per synchronizer chain, at least 2
`define LINK_SYNC_STAGES       2

`endif

// ==== hw/link_clk_pkg.sv ====
//##########################################################
// link clock block types: sequencer states, lock status
// and reset control bundles
//##########################################################
package link_clk_pkg;

   //##########################################################
   // reset sequencer states
   //##########################################################

   // power-up order, one step per heartbeat at most
   typedef enum logic [2:0]
   {
      RESET_ALL  = 3'd0,   // everything held
      START_PLL  = 3'd1,   // plls running, wait for core lock
      STOP_PLL   = 3'd2,   // plls held, quiet window
      START_CHIP = 3'd3,   // chip reset released, plls still held
      HOLD_CHIP  = 3'd4,   // plls restarted, wait for lock again
      ACTIVE     = 3'd5    // link logic released
   } seq_state_t;

   //##########################################################
   // status and control bundles
   //##########################################################

   // lock flags of the two pll models
   typedef struct packed
   {
      logic core_locked;   // core / tx pll
      logic rx_locked;     // rx pll
   } lock_status_t;

   // sequencer outputs
   typedef struct packed
   {
      logic pll_reset;     // active high, both plls
      logic chip_reset_n;  // attached chip, active low
      logic link_reset;    // link logic and io, active high
   } seq_ctrl_t;

endpackage

// ==== hw/link_clocks_top.sv ====
//##########################################################
// link clock and reset block: synchronizers, heartbeat,
// reset sequencer and two PLL lock models
//##########################################################
`timescale 1ns/100ps
`include "link_clk_consts.svh"

module link_clocks_top
   import link_clk_pkg::*;
(
   input  logic         sys_clk,
   input  logic         reset_in,    // power-on reset
   input  logic         link_en,     // link enable pin
   output seq_ctrl_t    ctrl,        // pll, chip and link resets
   output lock_status_t lock,        // raw model lock flags
   output logic         tx_div_en,   // tx parallel clock enable
   output logic         rx_div_en    // rx parallel clock enable
);

   //##########################################################
   // internal nets
   //##########################################################

   logic         link_en_sync;
   lock_status_t lock_sync;
   logic         tick;           // heartbeat step

   //##########################################################
   // input conditioning and timing base
   //##########################################################

   clock_input_sync u_sync
   (
      .sys_clk      (sys_clk),
      .reset_in     (reset_in),
      .link_en      (link_en),
      .lock         (lock),
      .link_en_sync (link_en_sync),
      .lock_sync    (lock_sync)
   );

   heartbeat_gen
   #(
      .WIDTH (`LINK_HB_WIDTH)
   ) u_heartbeat
   (
      .sys_clk  (sys_clk),
      .reset_in (reset_in),
      .tick     (tick)
   );

   //##########################################################
   // sequencer
   //##########################################################

   reset_sequencer u_seq
   (
      .sys_clk      (sys_clk),
      .reset_in     (reset_in),
      .tick         (tick),
      .link_en_sync (link_en_sync),
      .lock_sync    (lock_sync),
      .ctrl         (ctrl)
   );

   //##########################################################
   // pll stand-ins, both held by the same pll reset
   //##########################################################

   // core pll also carries the tx clocks
   pll_lock_model
   #(
      .LOCK_CYCLES (`LINK_CORE_LOCK_CYCLES),
      .DIV         (`LINK_TX_DIV)
   ) core_pll
   (
      .sys_clk   (sys_clk),
      .reset_in  (reset_in),
      .pll_reset (ctrl.pll_reset),
      .locked    (lock.core_locked),
      .div_en    (tx_div_en)
   );

   pll_lock_model
   #(
      .LOCK_CYCLES (`LINK_RX_LOCK_CYCLES),
      .DIV         (`LINK_RX_DIV)
   ) rx_pll
   (
      .sys_clk   (sys_clk),
      .reset_in  (reset_in),
      .pll_reset (ctrl.pll_reset),
      .locked    (lock.rx_locked),
      .div_en    (rx_div_en)
   );

endmodule

// ==== hw/pll_lock_model.sv ====
//##########################################################
// PLL stand-in: lock after a fixed delay, divided clock
// enable strobe while locked
//##########################################################
`timescale 1ns/100ps

module pll_lock_model
#(
   parameter int LOCK_CYCLES = 40,   // reset release to lock
   parameter int DIV         = 4     // strobe period in sys_clk cycles
)
(
   input  logic sys_clk,
   input  logic reset_in,
   input  logic pll_reset,           // from the sequencer
   output logic locked,
   output logic div_en               // one cycle per DIV while locked
);

   localparam int CW = $clog2(LOCK_CYCLES + 1);
   localparam int DW = $clog2(DIV + 1);

   logic [CW-1:0] lock_cnt;
   logic [DW-1:0] div_cnt;
   logic          div_q;

   //##########################################################
   // lock counter
   //##########################################################

   always_ff @(posedge sys_clk)
   begin
      if (reset_in || pll_reset)
      begin
         lock_cnt <= '0;   // lock lost the cycle after pll reset
         locked   <= 1'b0;
      end
      else if (!locked)
      begin
         lock_cnt <= lock_cnt + 1'b1;
         if (lock_cnt == CW'(LOCK_CYCLES - 1))
            locked <= 1'b1;
      end
   end

   //##########################################################
   // divided clock enable
   //##########################################################

   always_ff @(posedge sys_clk)
   begin
      if (reset_in || pll_reset || !locked)
      begin
         div_cnt <= '0;
         div_q   <= 1'b0;
      end
      else if (div_cnt == DW'(DIV - 1))
      begin
         div_cnt <= '0;
         div_q   <= 1'b1;   // first pulse DIV cycles after lock
      end
      else
      begin
         div_cnt <= div_cnt + 1'b1;
         div_q   <= 1'b0;
      end
   end

   // output clock stops as soon as the pll is held
   assign div_en = div_q & ~pll_reset;

endmodule

// ==== hw/reset_sequencer.sv ====
//##########################################################
// reset sequencer: six-state power-up FSM stepping on
// heartbeat ticks, drives PLL, chip and link resets
//##########################################################
`timescale 1ns/100ps

module reset_sequencer
   import link_clk_pkg::*;
(
   input  logic         sys_clk,
   input  logic         reset_in,
   input  logic         tick,          // heartbeat step
   input  logic         link_en_sync,  // low holds everything in reset
   input  lock_status_t lock_sync,     // synchronized lock flags
   output seq_ctrl_t    ctrl
);

   // everything held: plls and link in reset, chip in reset
   localparam seq_ctrl_t CTRL_HOLD = '{pll_reset: 1'b1, chip_reset_n: 1'b0, link_reset: 1'b1};

   seq_state_t state;
   seq_state_t state_next;
   seq_ctrl_t  ctrl_next;

   //##########################################################
   // next state
   //##########################################################

   always_comb
   begin
      state_next = state;
      if (!link_en_sync)
         state_next = RESET_ALL;            // disable wins, no tick needed
      else if (tick)
      begin
         case (state)
            RESET_ALL:  state_next = START_PLL;
            START_PLL:
            begin
               // only core lock gates progress, rx lock is status only
               if (lock_sync.core_locked)
                  state_next = STOP_PLL;
            end
            STOP_PLL:   state_next = START_CHIP;   // quiet window over
            START_CHIP: state_next = HOLD_CHIP;
            HOLD_CHIP:
            begin
               if (lock_sync.core_locked)   // relock after chip release
                  state_next = ACTIVE;
            end
            ACTIVE:     state_next = ACTIVE;       // held until next reset
            default:    state_next = RESET_ALL;    // unused codes
         endcase
      end
   end

   //##########################################################
   // output decode from next state
   //##########################################################

   // decoding the next state lets the registered outputs change
   // on the same edge as the state itself
   always_comb
   begin
      // plls quiet around the chip reset edge
      ctrl_next.pll_reset    = (state_next == RESET_ALL) ||
                               (state_next == STOP_PLL)  ||
                               (state_next == START_CHIP);
      ctrl_next.chip_reset_n = (state_next == START_CHIP) ||
                               (state_next == HOLD_CHIP)  ||
                               (state_next == ACTIVE);
      ctrl_next.link_reset   = (state_next != ACTIVE);    // released last
   end

   //##########################################################
   // state and control registers
   //##########################################################

   always_ff @(posedge sys_clk)
   begin
      if (reset_in)
      begin
         state <= RESET_ALL;
         ctrl  <= CTRL_HOLD;
      end
      else
      begin
         state <= state_next;
         ctrl  <= ctrl_next;   // glitch-free reset outputs
      end
   end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the link clock block testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

TOP=link_clocks_tb
OBJ=obj_dir
EXE=sim_link_clocks
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

# compile
verilator --binary --timing --assert -f build.f --top-module "$TOP" \
   -Mdir "$OBJ" -o "$EXE"
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

# run
"./$OBJ/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# result from the log
if grep -q "^TEST RESULT: PASS$" "$LOG"; then
   exit 0
else
   echo "pass line not found in $LOG"
   exit 1
fi
